/* build.f */
+incdir+include
verilog/cccPkg.sv
verilog/graphFeedIfc.sv
verilog/graphFifo.sv
verilog/slotMemory.sv
verilog/slotRing.sv
verilog/propagationControl.sv
verilog/labelEngine.sv
verilog/connectedCountCore.sv
tests/connectedCountCore_tb.sv

/* Makefile */
TB_TOP = connectedCountCore_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f build.f --top-module connectedCountCore

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TB_TOP) -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/connectedCountCore_tb.sv */
`include "ccc_defines.svh"

module connectedCountCore_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // One lap of the ring plus the registered read
    localparam int lapCycles = 65;
    // About 1000 cycles of tests plus headroom
    localparam int timeoutCycles = 3000;

    typedef struct {
        int due;
        logic [`CCC_TAG_BITS-1:0] tag;
        int count;
    } expectation_t;

    logic clk = 1'b0;
    logic rst;
    logic isBotValid;
    logic [`CCC_EDGE_BITS-1:0] graphIn;
    logic [`CCC_TAG_BITS-1:0] tagIn;
    logic freeze;
    logic almostFull;
    logic resultValid;
    logic [3:0] connectCount;
    logic [`CCC_TAG_BITS-1:0] tagOut;

    expectation_t pending [$];
    int stimCount;
    int unfrozenEdges = 0;
    int cycleCount = 0;
    int errorCount = 0;
    int testErrors;
    int testsRun = 0;
    int seed = 32;
    string testName = "reset";

    connectedCountCore dut_i (
        .clk(clk),
        .rst(rst),
        .isBotValid(isBotValid),
        .graphIn(graphIn),
        .tagIn(tagIn),
        .freeze(freeze),
        .almostFull(almostFull),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .tagOut(tagOut)
    );

    always #10 clk = ~clk;

    // Union-find reference over the upper triangle, (0,1) first
    function automatic int countComponents(input logic [`CCC_EDGE_BITS-1:0] edges);
        int parent [`CCC_NODES];
        logic [4:0] k;
        int a;
        int b;
        int roots;
        for (int n = 0; n < `CCC_NODES; n++) parent[n] = n;
        k = '0;
        for (int i = 0; i < `CCC_NODES; i++) begin
            for (int j = i + 1; j < `CCC_NODES; j++) begin
                if (edges[k]) begin
                    a = i;
                    while (parent[a] != a) a = parent[a];
                    b = j;
                    while (parent[b] != b) b = parent[b];
                    if (a != b) parent[b] = a;
                end
                k = k + 1'b1;
            end
        end
        roots = 0;
        for (int n = 0; n < `CCC_NODES; n++) begin
            if (parent[n] == n) roots++;
        end
        return roots;
    endfunction

    // All pairs with both ends inside lo..hi
    function automatic logic [`CCC_EDGE_BITS-1:0] cliqueMask(input int lo, input int hi);
        logic [`CCC_EDGE_BITS-1:0] mask;
        logic [4:0] k;
        mask = '0;
        k = '0;
        for (int i = 0; i < `CCC_NODES; i++) begin
            for (int j = i + 1; j < `CCC_NODES; j++) begin
                if (i >= lo && j <= hi) mask[k] = 1'b1;
                k = k + 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic logic [`CCC_EDGE_BITS-1:0] sparseGraph();
        return `CCC_EDGE_BITS'($random(seed) & $random(seed) & $random(seed));
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("** Error %s: %s expected %0d, actual %0d", testName, what, expected, actual);
        errorCount++;
    endtask

    // Input sampled at unfrozen edge n is due after unfrozen edge n+64
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (!rst && !freeze) begin
            unfrozenEdges = unfrozenEdges + 1;
            if (isBotValid) begin
                pending.push_back('{due: unfrozenEdges + lapCycles - 1, tag: tagIn,
                                    count: stimCount});
            end
        end
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("sim failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        expectation_t head;
        if (!rst) begin
            if (!freeze && pending.size() > 0 && pending[0].due == unfrozenEdges) begin
                head = pending.pop_front();
                assert (resultValid === 1'b1)
                    else reportMismatch("resultValid", 1, resultValid);
                assert (tagOut === head.tag) else reportMismatch("tagOut", head.tag, tagOut);
                assert (connectCount === 4'(head.count))
                    else reportMismatch("connectCount", head.count, connectCount);
            end else begin
                assert (resultValid === 1'b0)
                    else reportMismatch("resultValid", 0, resultValid);
            end
        end
    end

    task automatic presentGraph(input logic [`CCC_EDGE_BITS-1:0] edges,
                                input logic [`CCC_TAG_BITS-1:0] tag, input int count);
        @(posedge clk);
        isBotValid <= 1'b1;
        graphIn <= edges;
        tagIn <= tag;
        stimCount <= count;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            isBotValid <= 1'b0;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        idleCycles(1);
        while (pending.size() != 0) @(negedge clk);
        @(negedge clk);
        testsRun++;
        $display("%s: %0d errors", testName, errorCount - testErrors);
    endtask

    task automatic resetState();
        startTest("reset state");
        repeat (lapCycles) begin
            @(negedge clk);
            assert (almostFull === 1'b0) else reportMismatch("almostFull", 0, almostFull);
        end
        endTest();
    endtask

    task automatic knownGraphs();
        logic [`CCC_EDGE_BITS-1:0] path;
        startTest("known graphs");
        path = '0;
        for (int n = 0; n < `CCC_NODES - 1; n++) path = path | cliqueMask(n, n + 1);
        presentGraph('0, 8'h11, 8);
        endTest();
        presentGraph('1, 8'h22, 1);
        endTest();
        presentGraph(path, 8'h33, 1);
        endTest();
        presentGraph(cliqueMask(0, 3) | cliqueMask(4, 7), 8'h44, 2);
        endTest();
        presentGraph(cliqueMask(2, 2) | (cliqueMask(2, 5) & ~cliqueMask(2, 4)
                     & ~cliqueMask(3, 5)), 8'h55, 7);
        endTest();
    endtask

    task automatic emptySlots();
        logic [`CCC_EDGE_BITS-1:0] edges;
        startTest("empty slots");
        for (int g = 0; g < 4; g++) begin
            edges = sparseGraph();
            presentGraph(edges, 8'(8'hA0 + g), countComponents(edges));
            idleCycles(5 + 4 * g);
        end
        endTest();
    endtask

    task automatic randomBurst();
        logic [`CCC_EDGE_BITS-1:0] edges;
        logic canSend;
        startTest("random burst");
        for (int c = 0; c < 150; c++) begin
            @(negedge clk);
            canSend = !almostFull;
            edges = (c % 3 == 0) ? `CCC_EDGE_BITS'($random(seed)) : sparseGraph();
            @(posedge clk);
            isBotValid <= canSend;
            graphIn <= edges;
            tagIn <= 8'(c);
            stimCount <= countComponents(edges);
        end
        endTest();
    endtask

    task automatic freezeHold();
        logic [`CCC_EDGE_BITS-1:0] edges;
        startTest("freeze");
        for (int g = 0; g < 4; g++) begin
            edges = sparseGraph();
            presentGraph(edges, 8'(8'hC0 + g), countComponents(edges));
            idleCycles(4);
        end
        // First result sits on the outputs when freeze rises
        idleCycles(45);
        // Seven frozen edges, the monitor shifts every due point by the same amount
        @(posedge clk);
        freeze <= 1'b1;
        repeat (6) @(posedge clk);
        @(posedge clk);
        freeze <= 1'b0;
        endTest();
    endtask

    initial begin
        rst = 1'b1;
        isBotValid = 1'b0;
        graphIn = '0;
        tagIn = '0;
        freeze = 1'b0;
        stimCount = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        resetState();
        knownGraphs();
        emptySlots();
        randomBurst();
        freezeHold();
        $display("tests run %0d, errors %0d", testsRun, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog/connectedCountCore.sv */
`include "ccc_defines.svh"

module connectedCountCore import cccPkg::*; (
    input logic clk,
    input logic rst,
    input logic isBotValid,
    input logic [`CCC_EDGE_BITS-1:0] graphIn,
    input logic [`CCC_TAG_BITS-1:0] tagIn,
    input logic freeze,
    output logic almostFull,
    output logic resultValid,
    output logic [3:0] connectCount,
    output logic [`CCC_TAG_BITS-1:0] tagOut
);

    slotIdx_t slot;
    logic lapped;
    logic readLapped;
    fifoEntry_t pushEntry;
    validEntry_t validIn;
    validEntry_t validOut;
    compCount_t collectorOut;
    logic load;
    logic propagate;
    logic finish;
    logic resultWrite;
    slotIdx_t resultSlot;
    compCount_t resultCount;

    graphFeedIfc feed ();

    slotRing ring (.clk(clk), .rst(rst), .freeze(freeze), .slot(slot), .lapped(lapped));

    // Graph travels with the slot it must return to
    assign pushEntry = '{edges: graphIn, slot: slot};

    graphFifo inputFifo (
        .clk(clk),
        .rst(rst),
        .push(isBotValid),
        .pushData(pushEntry),
        .almostFull(almostFull),
        .feed(feed)
    );

    propagationControl control (
        .clk(clk),
        .rst(rst),
        .feed(feed),
        .load(load),
        .propagate(propagate),
        .finish(finish)
    );

    labelEngine engine (
        .clk(clk),
        .rst(rst),
        .feed(feed),
        .load(load),
        .propagate(propagate),
        .finish(finish),
        .resultWrite(resultWrite),
        .resultSlot(resultSlot),
        .resultCount(resultCount)
    );

    // Engine finishes well within one lap, so the write beats the read
    slotMemory #(.payload_t(compCount_t)) collector (
        .clk(clk),
        .writeEnable(resultWrite),
        .writeAddr(resultSlot),
        .writeData(resultCount),
        .readEnable(!freeze),
        .readAddr(slot),
        .readData(collectorOut)
    );

    assign validIn = '{valid: isBotValid, tag: tagIn};

    // Read returns the entry from one lap back, then it is overwritten
    slotMemory #(.payload_t(validEntry_t)) validMemory (
        .clk(clk),
        .writeEnable(!freeze),
        .writeAddr(slot),
        .writeData(validIn),
        .readEnable(!freeze),
        .readAddr(slot),
        .readData(validOut)
    );

    // Lapped as seen by the read now on the memory outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            readLapped <= 1'b0;
        end else if (!freeze) begin
            readLapped <= lapped;
        end
    end

    assign resultValid = validOut.valid && readLapped && !freeze;
    assign connectCount = collectorOut;
    assign tagOut = validOut.tag;

endmodule

/* verilog/labelEngine.sv */
`include "ccc_defines.svh"

module labelEngine import cccPkg::*; (
    input logic clk,
    input logic rst,
    graphFeedIfc.sink feed,
    input logic load,
    input logic propagate,
    input logic finish,
    output logic resultWrite,
    output slotIdx_t resultSlot,
    output compCount_t resultCount
);

    graphEdges_t edgesQ;
    slotIdx_t slotQ;
    nodeLabel_t labels [`CCC_NODES];
    nodeLabel_t nextLabels [`CCC_NODES];
    compCount_t rootCount;

    // Bit position of pair (a,b) in the upper triangle
    function automatic logic isLinked(graphEdges_t e, int a, int b);
        int lo;
        int hi;
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        return e[lo * (2 * `CCC_NODES - 1 - lo) / 2 + hi - lo - 1];
    endfunction

    // One pass of min over neighbors
    always_comb begin
        for (int n = 0; n < `CCC_NODES; n++) begin
            nextLabels[n] = labels[n];
            for (int m = 0; m < `CCC_NODES; m++) begin
                if (m != n && isLinked(edgesQ, n, m) && labels[m] < nextLabels[n]) begin
                    nextLabels[n] = labels[m];
                end
            end
        end
    end

    // A node still holding its own index is the root of its component
    always_comb begin
        rootCount = '0;
        for (int n = 0; n < `CCC_NODES; n++) begin
            if (labels[n] == nodeLabel_t'(n)) begin
                rootCount = rootCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            edgesQ <= feed.edges;
            slotQ <= feed.slot;
            for (int n = 0; n < `CCC_NODES; n++) begin
                labels[n] <= nodeLabel_t'(n);
            end
        end else if (propagate) begin
            labels <= nextLabels;
        end
        if (finish) begin
            resultSlot <= slotQ;
            resultCount <= rootCount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultWrite <= 1'b0;
        end else begin
            resultWrite <= finish;
        end
    end

endmodule

/* verilog/propagationControl.sv */
`include "ccc_defines.svh"

module propagationControl (
    input logic clk,
    input logic rst,
    graphFeedIfc.sink feed,
    output logic load,
    output logic propagate,
    output logic finish
);

    typedef enum logic [2:0] {
        stateIdle,
        stateFetch,
        stateLoad,
        statePropagate,
        stateFinish
    } ctrlState_t;

    localparam logic [2:0] lastIter = 3'(`CCC_PROP_ITERS - 1);

    ctrlState_t state;
    logic [2:0] iterCount;

    // Request, load, 7 passes, count; write lands 10 cycles after request
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stateIdle;
            iterCount <= '0;
        end else begin
            case (state)
                stateIdle: begin
                    if (feed.available) begin
                        state <= stateFetch;
                    end
                end
                stateFetch: state <= stateLoad;
                stateLoad: begin
                    state <= statePropagate;
                    iterCount <= '0;
                end
                statePropagate: begin
                    if (iterCount == lastIter) begin
                        state <= stateFinish;
                    end else begin
                        iterCount <= iterCount + 1'b1;
                    end
                end
                stateFinish: state <= stateIdle;
                default: state <= stateIdle;
            endcase
        end
    end

    assign feed.request = state == stateFetch;
    assign load = state == stateLoad;
    assign propagate = state == statePropagate;
    assign finish = state == stateFinish;

endmodule

/* verilog/slotRing.sv */
module slotRing import cccPkg::*; (
    input logic clk,
    input logic rst,
    input logic freeze,
    output slotIdx_t slot,
    output logic lapped
);

    // Index steps once per unfrozen cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
            lapped <= 1'b0;
        end else if (!freeze) begin
            slot <= slot + 1'b1;
            // First wrap means every slot has been written once
            if (slot == '1) begin
                lapped <= 1'b1;
            end
        end
    end

endmodule

/* verilog/slotMemory.sv */
`include "ccc_defines.svh"

module slotMemory import cccPkg::*; #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic writeEnable,
    input slotIdx_t writeAddr,
    input payload_t writeData,
    input logic readEnable,
    input slotIdx_t readAddr,
    output payload_t readData
);

    localparam int depth = 1 << `CCC_SLOT_BITS;

    payload_t storage [depth];

    // Same-address read and write returns the old entry
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            storage[writeAddr] <= writeData;
        end
        if (readEnable) begin
            readData <= storage[readAddr];
        end
    end

endmodule

/* verilog/graphFifo.sv */
`include "ccc_defines.svh"

module graphFifo import cccPkg::*; (
    input logic clk,
    input logic rst,
    input logic push,
    input fifoEntry_t pushData,
    output logic almostFull,
    graphFeedIfc.source feed
);

    localparam int depth = 1 << `CCC_FIFO_DEPTH_LOG2;
    localparam int almostFullLevel = depth - `CCC_ALMOST_FULL_MARGIN;

    fifoEntry_t storage [depth];
    fifoEntry_t headQ;

    logic [`CCC_FIFO_DEPTH_LOG2-1:0] writePtr;
    logic [`CCC_FIFO_DEPTH_LOG2-1:0] readPtr;
    logic [`CCC_FIFO_DEPTH_LOG2:0] occupancy;
    logic pop;

    assign pop = feed.request && feed.available;

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                writePtr <= writePtr + 1'b1;
            end
            if (pop) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({push, pop})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            storage[writePtr] <= pushData;
        end
        // Head shows up the cycle after a request
        if (pop) begin
            headQ <= storage[readPtr];
        end
    end

    assign almostFull = int'(occupancy) >= almostFullLevel;

    assign feed.available = occupancy != '0;
    assign feed.edges = headQ.edges;
    assign feed.slot = headQ.slot;

endmodule

/* verilog/graphFeedIfc.sv */
interface graphFeedIfc import cccPkg::*; ();

    logic available;
    logic request;
    graphEdges_t edges;
    slotIdx_t slot;

    // FIFO side
    modport source (
        output available,
        output edges,
        output slot,
        input request
    );

    // Engine side
    modport sink (
        input available,
        input edges,
        input slot,
        output request
    );

endinterface

/* verilog/cccPkg.sv */
`include "ccc_defines.svh"

package cccPkg;

    // Upper triangle, pairs (i,j) with i < j, i ascending then j ascending
    typedef logic [`CCC_EDGE_BITS-1:0] graphEdges_t;

    typedef logic [$clog2(`CCC_NODES)-1:0] nodeLabel_t;

    // Holds 1 to 8
    typedef logic [$clog2(`CCC_NODES+1)-1:0] compCount_t;

    typedef logic [`CCC_SLOT_BITS-1:0] slotIdx_t;
    typedef logic [`CCC_TAG_BITS-1:0] graphTag_t;

    typedef struct packed {
        graphEdges_t edges;
        slotIdx_t slot;
    } fifoEntry_t;

    // Input bookkeeping per ring slot
    typedef struct packed {
        logic valid;
        graphTag_t tag;
    } validEntry_t;

endpackage

/* include/ccc_defines.svh */
`ifndef CCC_DEFINES_SVH
`define CCC_DEFINES_SVH

// Graph shape
`define CCC_NODES 8
`define CCC_EDGE_BITS 28

// Ring of result slots
`define CCC_SLOT_BITS 6

// Input FIFO, 4 entries
`define CCC_FIFO_DEPTH_LOG2 2
`define CCC_ALMOST_FULL_MARGIN 2

// Enough passes to cross the longest path of 8 nodes
`define CCC_PROP_ITERS 7

`define CCC_TAG_BITS 8

`endif
